/* source/mem_pkg.sv */
package mem_pkg;

    // byte addressing throughout
    localparam int ADDR_W = 32;

    // one burst beat from backing memory
    localparam int BEAT_W = 64;

    localparam int BEATS_PER_LINE = 4;

    // a full line is one complete burst
    localparam int LINE_W = BEAT_W * BEATS_PER_LINE;

    localparam int LINE_OFFSET_W = $clog2(LINE_W / 8);  // 5 for 32 byte lines

endpackage : mem_pkg

/* source/fetch_pkg.sv */
package fetch_pkg;

    localparam int INSTR_W = 32;

    // 256 bit line holds eight words
    localparam int WORDS_PER_LINE = 8;

    typedef enum logic [1:0] {
        ST_LOOKUP = 2'd0,  // serve hits or spot a miss
        ST_REQ    = 2'd1,  // wait for ready, then pulse read
        ST_FILL   = 2'd2   // beats coming back
    } fetch_state_e;

endpackage : fetch_pkg

/* source/fetch_fsm.sv */
module fetch_fsm
    import mem_pkg::*;
    import fetch_pkg::*;
#(
    parameter logic [ADDR_W-1:0] RESET_PC = 32'hAAAAA000
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              hit_i,
    input  logic              queue_full_i,
    input  logic              fill_done_i,
    input  logic              bmem_ready_i,
    input  logic              redirect_i,
    input  logic [ADDR_W-1:0] redirect_pc_i,

    output logic [ADDR_W-1:0] pc_o,
    output logic [ADDR_W-1:0] fill_addr_o,
    output logic              bmem_read_o,
    output logic              enq_o,
    output logic [ADDR_W-1:0] enq_pc_o,
    output logic              flush_o
);

    fetch_state_e      state_q;
    fetch_state_e      state_d;
    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] fill_addr_q;

    // read goes out on the first ready cycle in ST_REQ
    assign bmem_read_o = (state_q == ST_REQ) && bmem_ready_i;

    // redirect beats a same-cycle enqueue
    assign enq_o    = (state_q == ST_LOOKUP) && hit_i && !queue_full_i && !redirect_i;
    assign enq_pc_o = pc_q;
    assign flush_o  = redirect_i;

    assign pc_o        = pc_q;
    assign fill_addr_o = fill_addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP: begin
                if (!hit_i && !redirect_i) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                if (bmem_read_o) begin
                    state_d = ST_FILL;
                end else if (redirect_i) begin
                    state_d = ST_LOOKUP;  // nothing sent yet so recheck new pc
                end
            end
            ST_FILL: begin
                if (fill_done_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: state_d = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_LOOKUP;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_d;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (enq_o) begin
                pc_q <= pc_q + ADDR_W'(4);
            end
        end
    end

    // line address of the miss latched on entry to ST_REQ
    always_ff @(posedge clk) begin
        if (state_q == ST_LOOKUP && state_d == ST_REQ) begin
            fill_addr_q <= {pc_q[ADDR_W-1:LINE_OFFSET_W], LINE_OFFSET_W'(0)};
        end
    end

    read_single_cycle: assert property (
        @(posedge clk) disable iff (rst) bmem_read_o |=> !bmem_read_o
    );

endmodule : fetch_fsm

/* source/beat_counter.sv */
module beat_counter
    import mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic beat_valid_i,
    output logic fill_done_o
);

    localparam int CNT_W = $clog2(BEATS_PER_LINE);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= '0;
            fill_done_o <= 1'b0;
        end else begin
            // pulse lands the cycle after the last beat
            fill_done_o <= beat_valid_i && (count_q == CNT_W'(BEATS_PER_LINE - 1));
            if (beat_valid_i) begin
                count_q <= count_q + CNT_W'(1);  // wraps back to 0
            end
        end
    end

    done_is_pulse: assert property (
        @(posedge clk) disable iff (rst) fill_done_o |=> !fill_done_o
    );

endmodule : beat_counter

/* source/line_assembler.sv */
module line_assembler
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              beat_valid_i,
    input  logic [ADDR_W-1:0] beat_addr_i,
    input  logic [BEAT_W-1:0] beat_data_i,
    output logic [LINE_W-1:0] line_o
);

    localparam int BYTE_OFF_W = $clog2(BEAT_W / 8);
    localparam int SLOT_W     = $clog2(BEATS_PER_LINE);

    logic [BEATS_PER_LINE-1:0][BEAT_W-1:0] line_q;
    logic [SLOT_W-1:0]                     slot;

    // addr bits 4:3 pick the slot, so beat order does not matter
    assign slot = beat_addr_i[BYTE_OFF_W +: SLOT_W];

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            line_q[slot] <= beat_data_i;
        end
    end

    assign line_o = line_q;

endmodule : line_assembler

/* source/line_buffer.sv */
module line_buffer
    import mem_pkg::*;
    import fetch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               load_i,
    input  logic [ADDR_W-1:0]  load_addr_i,
    input  logic [LINE_W-1:0]  line_i,
    input  logic [ADDR_W-1:0]  pc_i,
    output logic               hit_o,
    output logic [INSTR_W-1:0] word_o
);

    localparam int TAG_W      = ADDR_W - LINE_OFFSET_W;
    localparam int WORD_LSB   = $clog2(INSTR_W / 8);
    localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

    logic                                  valid_q;
    logic [TAG_W-1:0]                      tag_q;
    logic [WORDS_PER_LINE-1:0][INSTR_W-1:0] line_q;
    logic [WORD_SEL_W-1:0]                 word_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            tag_q  <= load_addr_i[ADDR_W-1 -: TAG_W];
            line_q <= line_i;
        end
    end

    assign hit_o = valid_q && (pc_i[ADDR_W-1 -: TAG_W] == tag_q);

    // pc bits 4:2
    assign word_sel = pc_i[WORD_LSB +: WORD_SEL_W];
    assign word_o   = line_q[word_sel];

endmodule : line_buffer

/* source/instr_queue.sv */
module instr_queue
    import mem_pkg::*;
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               enq_i,
    input  logic [INSTR_W-1:0] enq_instr_i,
    input  logic [ADDR_W-1:0]  enq_pc_i,
    input  logic               deq_i,
    input  logic               flush_i,

    output logic               full_o,
    output logic               valid_o,
    output logic [INSTR_W-1:0] head_instr_o,
    output logic [ADDR_W-1:0]  head_pc_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [INSTR_W-1:0] instr_mem [QUEUE_DEPTH];
    logic [ADDR_W-1:0]  pc_mem    [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_enq;
    logic             do_deq;

    assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
    assign valid_o = (count_q != '0);

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && valid_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);  // depth is a power of two
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            count_q <= count_q + CNT_W'(do_enq) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            instr_mem[wr_ptr_q] <= enq_instr_i;
            pc_mem[wr_ptr_q]    <= enq_pc_i;
        end
    end

    assign head_instr_o = instr_mem[rd_ptr_q];
    assign head_pc_o    = pc_mem[rd_ptr_q];

    // fetch side must respect full
    no_enq_when_full: assert property (
        @(posedge clk) disable iff (rst) enq_i |-> !full_o
    );

    no_deq_when_empty: assert property (
        @(posedge clk) disable iff (rst) deq_i |-> valid_o
    );

endmodule : instr_queue

/* source/fetch_top.sv */
module fetch_top
    import mem_pkg::*;
    import fetch_pkg::*;
#(
    parameter logic [ADDR_W-1:0] RESET_PC    = 32'hAAAAA000,
    parameter int                QUEUE_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst,

    // backing memory
    output logic [ADDR_W-1:0]  bmem_addr_o,
    output logic               bmem_read_o,
    input  logic               bmem_ready_i,
    input  logic [ADDR_W-1:0]  bmem_raddr_i,
    input  logic [BEAT_W-1:0]  bmem_rdata_i,
    input  logic               bmem_rvalid_i,

    // decode
    output logic [INSTR_W-1:0] instr_o,
    output logic [ADDR_W-1:0]  instr_pc_o,
    output logic               instr_valid_o,
    input  logic               instr_ack_i,
    input  logic               redirect_i,
    input  logic [ADDR_W-1:0]  redirect_pc_i
);

    logic               hit;
    logic               queue_full;
    logic               fill_done;
    logic [ADDR_W-1:0]  pc;
    logic [ADDR_W-1:0]  fill_addr;
    logic               enq;
    logic [ADDR_W-1:0]  enq_pc;
    logic               flush;
    logic [INSTR_W-1:0] word;
    logic [LINE_W-1:0]  line;
    logic               deq;

    assign bmem_addr_o = fill_addr;
    assign deq         = instr_ack_i && instr_valid_o;  // ack on empty is ignored

    fetch_fsm #(
        .RESET_PC      (RESET_PC)
    ) i_fetch_fsm (
        .clk           (clk),
        .rst           (rst),
        .hit_i         (hit),
        .queue_full_i  (queue_full),
        .fill_done_i   (fill_done),
        .bmem_ready_i  (bmem_ready_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc),
        .fill_addr_o   (fill_addr),
        .bmem_read_o   (bmem_read_o),
        .enq_o         (enq),
        .enq_pc_o      (enq_pc),
        .flush_o       (flush)
    );

    beat_counter i_beat_counter (
        .clk           (clk),
        .rst           (rst),
        .beat_valid_i  (bmem_rvalid_i),
        .fill_done_o   (fill_done)
    );

    line_assembler i_line_assembler (
        .clk           (clk),
        .beat_valid_i  (bmem_rvalid_i),
        .beat_addr_i   (bmem_raddr_i),
        .beat_data_i   (bmem_rdata_i),
        .line_o        (line)
    );

    // tag comes from the fill address, not the current pc
    line_buffer i_line_buffer (
        .clk           (clk),
        .rst           (rst),
        .load_i        (fill_done),
        .load_addr_i   (fill_addr),
        .line_i        (line),
        .pc_i          (pc),
        .hit_o         (hit),
        .word_o        (word)
    );

    instr_queue #(
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) i_instr_queue (
        .clk           (clk),
        .rst           (rst),
        .enq_i         (enq),
        .enq_instr_i   (word),
        .enq_pc_i      (enq_pc),
        .deq_i         (deq),
        .flush_i       (flush),
        .full_o        (queue_full),
        .valid_o       (instr_valid_o),
        .head_instr_o  (instr_o),
        .head_pc_o     (instr_pc_o)
    );

endmodule : fetch_top

/* verif/burst_mem_model.sv */
module burst_mem_model
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              irregular_i,
    input  logic              read_i,
    input  logic [ADDR_W-1:0] addr_i,
    output logic              ready_o,
    output logic [ADDR_W-1:0] raddr_o,
    output logic [BEAT_W-1:0] rdata_o,
    output logic              rvalid_o,
    output int                read_count_o,
    output int                bad_read_count_o,
    output logic [ADDR_W-1:0] last_addr_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]       rng;
    logic              busy;
    logic [1:0]        rot;
    logic [ADDR_W-1:0] base;
    int                served;
    int                wait_cnt;
    int                beat_idx;
    int                hold_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // inverted low address bits on top
    function automatic logic [31:0] word_at(input logic [ADDR_W-1:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    // read pulses counted at the edge where the DUT sends them
    always @(posedge clk) begin
        if (rst) begin
            read_count_o     <= 0;
            bad_read_count_o <= 0;
            last_addr_o      <= '0;
        end else if (read_i) begin
            read_count_o <= read_count_o + 1;
            last_addr_o  <= addr_i;
            if (!ready_o) begin
                bad_read_count_o <= bad_read_count_o + 1;
            end
        end
    end

    initial begin
        ready_o  = 1'b0;
        raddr_o  = '0;
        rdata_o  = '0;
        rvalid_o = 1'b0;
        rng      = 32'd7;
        busy     = 1'b0;
        served   = 0;
        hold_cnt = 0;
        forever begin
            @(negedge clk);
            rvalid_o = 1'b0;
            if (rst) begin
                busy     = 1'b0;
                served   = 0;
                hold_cnt = 0;
                ready_o  = 1'b1;
            end else if (busy) begin
                if (wait_cnt > 0) begin
                    wait_cnt--;
                end else begin
                    raddr_o  = base + ADDR_W'(8 * ((beat_idx + int'(rot)) % BEATS_PER_LINE));
                    rdata_o  = {word_at(raddr_o + 32'd4), word_at(raddr_o)};
                    rvalid_o = 1'b1;
                    beat_idx++;
                    rng      = xorshift32(rng);
                    wait_cnt = irregular_i ? int'(rng % 32'd3) : 0;  // gap 0 to 2
                    busy     = (beat_idx < BEATS_PER_LINE);
                end
            end else if (served != read_count_o) begin
                served++;
                busy     = 1'b1;
                ready_o  = 1'b0;  // one burst at a time
                base     = last_addr_o;
                beat_idx = 0;
                rng      = xorshift32(rng);
                rot      = irregular_i ? rng[1:0] : 2'd0;
                wait_cnt = irregular_i ? 2 + int'(rng[31:8]) % 5 : 2;
            end else if (irregular_i) begin
                // ready low for stretches, high most of the time
                if (hold_cnt > 0) begin
                    hold_cnt--;
                end else begin
                    rng      = xorshift32(rng);
                    ready_o  = (rng[1:0] != 2'd0);
                    hold_cnt = 1 + int'(rng[6:4]);
                end
            end else begin
                ready_o = 1'b1;
            end
        end
    end

endmodule : burst_mem_model

/* verif/fetch_tb.sv */
module fetch_tb
    import mem_pkg::*;
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [ADDR_W-1:0] RESET_PC    = 32'hAAAAA000;
    localparam int                QUEUE_DEPTH = 16;
    localparam int                MAX_CYCLES  = 20000;  // six tests of up to ~1500 cycles

    logic               clk;
    logic               rst;
    logic [ADDR_W-1:0]  bmem_addr;
    logic               bmem_read;
    logic               bmem_ready;
    logic [ADDR_W-1:0]  bmem_raddr;
    logic [BEAT_W-1:0]  bmem_rdata;
    logic               bmem_rvalid;
    logic [INSTR_W-1:0] instr;
    logic [ADDR_W-1:0]  instr_pc;
    logic               instr_valid;
    logic               instr_ack;
    logic               redirect;
    logic [ADDR_W-1:0]  redirect_pc;
    logic               irregular;
    int                 read_count;
    int                 bad_read_count;
    logic [ADDR_W-1:0]  last_read_addr;

    int                 cycles = 0;
    int                 checks = 0;
    int                 errors = 0;
    int                 tests  = 0;
    logic [ADDR_W-1:0]  next_pc;  // pc expected at the queue head

    fetch_top #(
        .RESET_PC      (RESET_PC),
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) i_fetch_top (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .instr_o       (instr),
        .instr_pc_o    (instr_pc),
        .instr_valid_o (instr_valid),
        .instr_ack_i   (instr_ack),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc)
    );

    burst_mem_model i_burst_mem_model (
        .clk              (clk),
        .rst              (rst),
        .irregular_i      (irregular),
        .read_i           (bmem_read),
        .addr_i           (bmem_addr),
        .ready_o          (bmem_ready),
        .raddr_o          (bmem_raddr),
        .rdata_o          (bmem_rdata),
        .rvalid_o         (bmem_rvalid),
        .read_count_o     (read_count),
        .bad_read_count_o (bad_read_count),
        .last_addr_o      (last_read_addr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] instr_at(input logic [ADDR_W-1:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("check failed: %s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failed checks", name, errors - err_before);
        end
    endtask

    // ack whenever the head is valid and compare with the data rule
    task automatic drain_and_check(input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            instr_ack = 1'b0;
            if (instr_valid) begin
                check_value("instr_pc_o", next_pc, instr_pc);
                check_value("instr_o", instr_at(next_pc), instr);
                instr_ack = 1'b1;
                next_pc   = next_pc + 32'd4;
                got++;
            end
        end
        @(negedge clk);
        instr_ack = 1'b0;
    endtask

    task automatic redirect_to(input logic [ADDR_W-1:0] target);
        @(negedge clk);
        instr_ack   = 1'b0;
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect = 1'b0;
        expect_true(!instr_valid, "queue still valid the cycle after a redirect");
        next_pc = target;
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        repeat (16) begin
            @(negedge clk);
            expect_true(!instr_valid && !bmem_read, "valid or read high during reset");
        end
        rst = 1'b0;
        // first cycle out of reset
        expect_true(!instr_valid && !bmem_read, "valid or read high just after reset");
        while (read_count == 0) begin
            @(negedge clk);
        end
        check_value("bmem_addr_o", RESET_PC & ~32'h1F, last_read_addr);
        report_test("reset", err0);
    endtask

    task automatic sequential_stream();
        int err0;
        err0    = errors;
        next_pc = RESET_PC;
        drain_and_check(40);  // five lines
        report_test("sequential", err0);
    endtask

    task automatic backpressure_stall();
        int err0;
        err0 = errors;
        repeat (100) @(negedge clk);
        expect_true(instr_valid, "queue empty after a stall");
        drain_and_check(40);
        report_test("backpressure", err0);
    endtask

    task automatic redirect_flush();
        int err0;
        err0 = errors;
        while (!instr_valid) begin
            @(negedge clk);
        end
        redirect_to(32'h0001_2354);  // word 5 of its line
        drain_and_check(12);
        report_test("redirect", err0);
    endtask

    task automatic irregular_memory();
        int err0;
        int reads0;
        err0      = errors;
        reads0    = read_count;
        irregular = 1'b1;
        redirect_to(32'h0002_0008);
        drain_and_check(48);
        expect_true(bad_read_count == 0, "read pulse sent while memory was not ready");
        expect_true(read_count > reads0, "no read pulse seen during the test");
        report_test("irregular_memory", err0);
    endtask

    task automatic line_reuse();
        int err0;
        int reads0;
        err0 = errors;
        // without acks the third fill is line 0x40040
        redirect_to(32'h0004_001C);
        reads0 = read_count;
        while (read_count < reads0 + 3) begin
            @(negedge clk);
        end
        redirect_to(32'h0004_0048);
        reads0 = read_count;
        while (!instr_valid) begin
            @(negedge clk);
        end
        check_value("read count", reads0, read_count);
        drain_and_check(6);
        report_test("line_reuse", err0);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_ack   = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        irregular   = 1'b0;
        next_pc     = RESET_PC;
        reset_state();
        sequential_stream();
        backpressure_stall();
        redirect_flush();
        irregular_memory();
        line_reuse();
        $display("summary: %0d tests, %0d checks, %0d failed", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : fetch_tb

/* all.f */
source/mem_pkg.sv
source/fetch_pkg.sv
source/fetch_fsm.sv
source/beat_counter.sv
source/line_assembler.sv
source/line_buffer.sv
source/instr_queue.sv
source/fetch_top.sv
verif/burst_mem_model.sv
verif/fetch_tb.sv

/* Makefile */
BIN := obj_dir/Vfetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module fetch_tb -f all.f

run: compile
	./$(BIN) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
